// File: hw/tlb_cp0_regs.sv
`timescale 1ns/100ps

module tlb_cp0_regs (
    input  logic                aclk,
    input  logic                rst,
    input  tlb_pkg::wb_req_t    wb_req,
    input  logic                reg_wr,
    input  logic                cmd_valid,
    input  tlb_pkg::tlb_cmd_e   cmd,
    input  tlb_pkg::tlb_entry_t entries [tlb_pkg::TLB_ENTRIES],
    output tlb_pkg::word_t      rd_data,
    output tlb_pkg::asid_t      cur_asid,
    output logic                arr_we,
    output tlb_pkg::tlb_idx_t   arr_widx,
    output tlb_pkg::tlb_entry_t arr_wentry
);

    tlb_pkg::vpn2_t      hi_vpn2;
    tlb_pkg::asid_t      hi_asid;
    tlb_pkg::tlb_page_t  lo0;
    tlb_pkg::tlb_page_t  lo1;
    logic                lo0_g;
    logic                lo1_g;
    logic                idx_p;
    tlb_pkg::tlb_idx_t   idx_q;
    tlb_pkg::tlb_idx_t   random_q;
    logic                probe_found;
    tlb_pkg::tlb_idx_t   probe_idx;
    tlb_pkg::tlb_entry_t rd_entry;

    function automatic tlb_pkg::word_t pack_lo(tlb_pkg::tlb_page_t pg, logic g);
        tlb_pkg::word_t w;
        w = '0;
        w[tlb_pkg::LO_PFN_LSB +: $bits(tlb_pkg::pfn_t)] = pg.pfn;
        w[tlb_pkg::LO_C_LSB +: $bits(tlb_pkg::cattr_t)] = pg.c;
        w[2] = pg.d;
        w[1] = pg.v;
        w[0] = g;
        return w;
    endfunction

    function automatic tlb_pkg::tlb_page_t unpack_lo(tlb_pkg::word_t w);
        tlb_pkg::tlb_page_t pg;
        pg.pfn = w[tlb_pkg::LO_PFN_LSB +: $bits(tlb_pkg::pfn_t)];
        pg.c   = w[tlb_pkg::LO_C_LSB +: $bits(tlb_pkg::cattr_t)];
        pg.d   = w[2];
        pg.v   = w[1];
        return pg;
    endfunction

    tlb_match probe_i (
        .entries (entries     ),
        .vpn2    (hi_vpn2     ),
        .asid    (hi_asid     ),
        .found   (probe_found ),
        .idx     (probe_idx   )
    );

    assign rd_entry = entries[idx_q];

    always_ff @(posedge aclk) begin
        if (rst) begin
            hi_vpn2  <= '0;
            hi_asid  <= '0;
            lo0      <= '0;
            lo1      <= '0;
            lo0_g    <= 1'b0;
            lo1_g    <= 1'b0;
            idx_p    <= 1'b0;
            idx_q    <= '0;
            random_q <= '1;
        end else if (reg_wr) begin
            case (wb_req.adr)
                tlb_pkg::ADR_INDEX: begin
                    idx_p <= wb_req.dat[tlb_pkg::INDEX_P_BIT];
                    idx_q <= wb_req.dat[$bits(tlb_pkg::tlb_idx_t)-1:0];
                end
                tlb_pkg::ADR_ENTRYLO0: begin
                    lo0   <= unpack_lo(wb_req.dat);
                    lo0_g <= wb_req.dat[0];
                end
                tlb_pkg::ADR_ENTRYLO1: begin
                    lo1   <= unpack_lo(wb_req.dat);
                    lo1_g <= wb_req.dat[0];
                end
                tlb_pkg::ADR_ENTRYHI: begin
                    hi_vpn2 <= wb_req.dat[tlb_pkg::HI_VPN2_LSB +: $bits(tlb_pkg::vpn2_t)];
                    hi_asid <= wb_req.dat[$bits(tlb_pkg::asid_t)-1:0];
                end
                default: ; // random is read only
            endcase
        end else if (cmd_valid) begin
            case (cmd)
                tlb_pkg::CMD_TLBP: begin
                    idx_p <= !probe_found;
                    if (probe_found) begin
                        idx_q <= probe_idx;
                    end
                end
                tlb_pkg::CMD_TLBR: begin
                    hi_vpn2 <= rd_entry.vpn2;
                    hi_asid <= rd_entry.asid;
                    lo0     <= rd_entry.page0;
                    lo1     <= rd_entry.page1;
                    lo0_g   <= rd_entry.g;
                    lo1_g   <= rd_entry.g;
                end
                tlb_pkg::CMD_TLBWR: begin
                    random_q <= random_q - 1'b1; // wraps 0 -> 15
                end
                default: ;
            endcase
        end
    end

    assign arr_we   = cmd_valid && (cmd == tlb_pkg::CMD_TLBWI || cmd == tlb_pkg::CMD_TLBWR);
    assign arr_widx = (cmd == tlb_pkg::CMD_TLBWR) ? random_q : idx_q;

    always_comb begin
        arr_wentry.used  = 1'b1;
        arr_wentry.vpn2  = hi_vpn2;
        arr_wentry.asid  = hi_asid;
        arr_wentry.g     = lo0_g && lo1_g; // global only if both halves say so
        arr_wentry.page0 = lo0;
        arr_wentry.page1 = lo1;
    end

    assign cur_asid = hi_asid;

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            tlb_pkg::ADR_INDEX: begin
                rd_data[tlb_pkg::INDEX_P_BIT] = idx_p;
                rd_data[$bits(tlb_pkg::tlb_idx_t)-1:0] = idx_q;
            end
            tlb_pkg::ADR_ENTRYLO0: rd_data = pack_lo(lo0, lo0_g);
            tlb_pkg::ADR_ENTRYLO1: rd_data = pack_lo(lo1, lo1_g);
            tlb_pkg::ADR_ENTRYHI: begin
                rd_data[tlb_pkg::HI_VPN2_LSB +: $bits(tlb_pkg::vpn2_t)] = hi_vpn2;
                rd_data[$bits(tlb_pkg::asid_t)-1:0] = hi_asid;
            end
            tlb_pkg::ADR_RANDOM: rd_data[$bits(tlb_pkg::tlb_idx_t)-1:0] = random_q;
            default: rd_data = '0; // command reads as zero
        endcase
    end

endmodule

// File: hw/tlb_ctrl.sv
`timescale 1ns/100ps

module tlb_ctrl (
    input  logic              aclk,
    input  logic              rst,
    input  tlb_pkg::wb_req_t  wb_req,
    output tlb_pkg::wb_rsp_t  wb_rsp,
    input  tlb_pkg::word_t    rd_data,
    output logic              reg_wr,
    output logic              cmd_valid,
    output tlb_pkg::tlb_cmd_e cmd
);

    tlb_pkg::ctrl_state_e state;
    tlb_pkg::ctrl_state_e state_nxt;
    tlb_pkg::tlb_cmd_e    cmd_q;
    logic                 req;
    logic                 is_cmd;

    assign req    = wb_req.cyc && wb_req.stb;
    assign is_cmd = wb_req.we && (wb_req.adr == tlb_pkg::ADR_COMMAND);

    always_comb begin
        state_nxt = state;
        case (state)
            tlb_pkg::ST_IDLE: begin
                if (req) begin
                    // commands take one extra cycle to run
                    if (is_cmd) begin
                        state_nxt = tlb_pkg::ST_EXEC;
                    end else begin
                        state_nxt = tlb_pkg::ST_ACK;
                    end
                end
            end
            tlb_pkg::ST_EXEC: begin
                state_nxt = tlb_pkg::ST_ACK;
            end
            tlb_pkg::ST_ACK: begin
                state_nxt = tlb_pkg::ST_IDLE;
            end
            default: begin
                state_nxt = tlb_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= tlb_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == tlb_pkg::ST_IDLE && req && is_cmd) begin
            cmd_q <= tlb_pkg::tlb_cmd_e'(wb_req.dat[1:0]);
        end
    end

    // register write lands on the sampling edge
    assign reg_wr = (state == tlb_pkg::ST_IDLE) && req && wb_req.we && !is_cmd;

    assign cmd_valid = (state == tlb_pkg::ST_EXEC);
    assign cmd       = cmd_q;

    assign wb_rsp.ack = (state == tlb_pkg::ST_ACK);
    assign wb_rsp.dat = rd_data; // adr still held by master

endmodule

// File: hw/tlb_entry_array.sv
`timescale 1ns/100ps

module tlb_entry_array (
    input  logic                aclk,
    input  logic                rst,
    input  logic                we,
    input  tlb_pkg::tlb_idx_t   widx,
    input  tlb_pkg::tlb_entry_t wentry,
    output tlb_pkg::tlb_entry_t entries [tlb_pkg::TLB_ENTRIES]
);

    tlb_pkg::tlb_entry_t             mem [tlb_pkg::TLB_ENTRIES];
    logic [tlb_pkg::TLB_ENTRIES-1:0] used_q;

    // valid bits, cleared on reset
    always_ff @(posedge aclk) begin
        if (rst) begin
            used_q <= '0;
        end else if (we) begin
            used_q[widx] <= wentry.used;
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            mem[widx] <= wentry;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin
            entries[i]      = mem[i];
            entries[i].used = used_q[i]; // stored copy may be stale after reset
        end
    end

endmodule

// File: hw/tlb_lookup_port.sv
`timescale 1ns/100ps

module tlb_lookup_port (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  tlb_pkg::vpn_t        req_vpn,
    input  tlb_pkg::asid_t       asid,
    input  tlb_pkg::tlb_entry_t  entries [tlb_pkg::TLB_ENTRIES],
    output logic                 res_valid,
    output tlb_pkg::tlb_result_t res
);

    logic                 hit;
    tlb_pkg::tlb_idx_t    hit_idx;
    tlb_pkg::tlb_entry_t  hit_entry;
    tlb_pkg::tlb_result_t res_d;

    tlb_match match_i (
        .entries (entries                                 ),
        .vpn2    (req_vpn[$bits(tlb_pkg::vpn_t)-1:1]      ),
        .asid    (asid                                    ),
        .found   (hit                                     ),
        .idx     (hit_idx                                 )
    );

    assign hit_entry = entries[hit_idx];

    always_comb begin
        res_d.found = hit;
        res_d.page  = '0; // miss returns a zero page
        if (hit) begin
            res_d.page = req_vpn[0] ? hit_entry.page1 : hit_entry.page0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            res <= res_d;
        end
    end

endmodule

// File: hw/tlb_match.sv
`timescale 1ns/100ps

module tlb_match (
    input  tlb_pkg::tlb_entry_t entries [tlb_pkg::TLB_ENTRIES],
    input  tlb_pkg::vpn2_t      vpn2,
    input  tlb_pkg::asid_t      asid,
    output logic                found,
    output tlb_pkg::tlb_idx_t   idx
);

    logic [tlb_pkg::TLB_ENTRIES-1:0] hit;

    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin
            hit[i] = entries[i].used
                  && (entries[i].vpn2 == vpn2)
                  && (entries[i].g || (entries[i].asid == asid));
        end
    end

    always_comb begin
        found = |hit;
        idx   = '0;
        // walk downwards so the lowest hit is kept
        for (int i = tlb_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                idx = tlb_pkg::tlb_idx_t'(i);
            end
        end
    end

endmodule

// File: hw/tlb_pkg.sv
package tlb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [19:0] vpn_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [3:0]  tlb_idx_t;
    typedef logic [2:0]  reg_adr_t;

    localparam int TLB_ENTRIES = 16;

    // register word addresses
    localparam reg_adr_t ADR_INDEX    = 3'd0;
    localparam reg_adr_t ADR_ENTRYLO0 = 3'd1;
    localparam reg_adr_t ADR_ENTRYLO1 = 3'd2;
    localparam reg_adr_t ADR_ENTRYHI  = 3'd3;
    localparam reg_adr_t ADR_COMMAND  = 3'd4;
    localparam reg_adr_t ADR_RANDOM   = 3'd5;

    localparam int LO_PFN_LSB  = 6;
    localparam int LO_C_LSB    = 3;
    localparam int HI_VPN2_LSB = 13;
    localparam int INDEX_P_BIT = 31;

    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;
        logic   v;
    } tlb_page_t;

    typedef struct packed {
        logic      used;
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t page0; // even page
        tlb_page_t page1; // odd page
    } tlb_entry_t;

    typedef struct packed {
        logic      found;
        tlb_page_t page;
    } tlb_result_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        reg_adr_t adr;
        word_t    dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        CMD_TLBP  = 2'd0,
        CMD_TLBR  = 2'd1,
        CMD_TLBWI = 2'd2,
        CMD_TLBWR = 2'd3
    } tlb_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_ACK
    } ctrl_state_e;

endpackage

// File: hw/tlb_top.sv
`timescale 1ns/100ps

module tlb_top (
    input  logic                 aclk,
    input  logic                 rst,
    input  tlb_pkg::wb_req_t     wb_req,
    output tlb_pkg::wb_rsp_t     wb_rsp,
    input  logic                 i_req_valid,
    input  tlb_pkg::vpn_t        i_req_vpn,
    output logic                 i_res_valid,
    output tlb_pkg::tlb_result_t i_res,
    input  logic                 d_req_valid,
    input  tlb_pkg::vpn_t        d_req_vpn,
    output logic                 d_res_valid,
    output tlb_pkg::tlb_result_t d_res
);

    tlb_pkg::word_t      rd_data;
    logic                reg_wr;
    logic                cmd_valid;
    tlb_pkg::tlb_cmd_e   cmd;
    tlb_pkg::asid_t      cur_asid;
    logic                arr_we;
    tlb_pkg::tlb_idx_t   arr_widx;
    tlb_pkg::tlb_entry_t arr_wentry;
    tlb_pkg::tlb_entry_t entries [tlb_pkg::TLB_ENTRIES];

    tlb_ctrl ctrl_i (
        .aclk      (aclk      ),
        .rst       (rst       ),
        .wb_req    (wb_req    ),
        .wb_rsp    (wb_rsp    ),
        .rd_data   (rd_data   ),
        .reg_wr    (reg_wr    ),
        .cmd_valid (cmd_valid ),
        .cmd       (cmd       )
    );

    tlb_cp0_regs cp0_i (
        .aclk       (aclk       ),
        .rst        (rst        ),
        .wb_req     (wb_req     ),
        .reg_wr     (reg_wr     ),
        .cmd_valid  (cmd_valid  ),
        .cmd        (cmd        ),
        .entries    (entries    ),
        .rd_data    (rd_data    ),
        .cur_asid   (cur_asid   ),
        .arr_we     (arr_we     ),
        .arr_widx   (arr_widx   ),
        .arr_wentry (arr_wentry )
    );

    tlb_entry_array array_i (
        .aclk    (aclk       ),
        .rst     (rst        ),
        .we      (arr_we     ),
        .widx    (arr_widx   ),
        .wentry  (arr_wentry ),
        .entries (entries    )
    );

    // instruction fetch side
    tlb_lookup_port itlb_i (
        .aclk      (aclk        ),
        .rst       (rst         ),
        .req_valid (i_req_valid ),
        .req_vpn   (i_req_vpn   ),
        .asid      (cur_asid    ),
        .entries   (entries     ),
        .res_valid (i_res_valid ),
        .res       (i_res       )
    );

    // data access side
    tlb_lookup_port dtlb_i (
        .aclk      (aclk        ),
        .rst       (rst         ),
        .req_valid (d_req_valid ),
        .req_vpn   (d_req_vpn   ),
        .asid      (cur_asid    ),
        .entries   (entries     ),
        .res_valid (d_res_valid ),
        .res       (d_res       )
    );

endmodule

// File: tb.f
+incdir+tb
hw/tlb_pkg.sv
hw/tlb_match.sv
hw/tlb_entry_array.sv
hw/tlb_lookup_port.sv
hw/tlb_cp0_regs.sv
hw/tlb_ctrl.sv
hw/tlb_top.sv
tb/tlb_tb.sv

// File: tb/tlb_tb_ref.svh
`ifndef TLB_TB_REF_SVH
`define TLB_TB_REF_SVH

// model state, mirrors the 16 entries and the cp0 registers
tlb_pkg::tlb_entry_t ref_tlb [tlb_pkg::TLB_ENTRIES];
tlb_pkg::word_t      ref_hi;
tlb_pkg::word_t      ref_lo0;
tlb_pkg::word_t      ref_lo1;
tlb_pkg::word_t      ref_index;
tlb_pkg::tlb_idx_t   ref_random;

task automatic ref_reset();
    for (int i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin
        ref_tlb[i] = '0;
    end
    ref_hi     = '0;
    ref_lo0    = '0;
    ref_lo1    = '0;
    ref_index  = '0;
    ref_random = 4'd15;
endtask

// expected read data
function automatic tlb_pkg::word_t ref_reg(input tlb_pkg::reg_adr_t adr);
    case (adr)
        tlb_pkg::ADR_INDEX:    return ref_index;
        tlb_pkg::ADR_ENTRYLO0: return ref_lo0;
        tlb_pkg::ADR_ENTRYLO1: return ref_lo1;
        tlb_pkg::ADR_ENTRYHI:  return ref_hi;
        tlb_pkg::ADR_RANDOM:   return {28'b0, ref_random};
        default:               return '0;
    endcase
endfunction

task automatic ref_write_reg(input tlb_pkg::reg_adr_t adr, input tlb_pkg::word_t dat);
    case (adr)
        tlb_pkg::ADR_INDEX:    ref_index = dat & 32'h8000_000f; // P and index
        tlb_pkg::ADR_ENTRYLO0: ref_lo0   = dat & 32'h03ff_ffff;
        tlb_pkg::ADR_ENTRYLO1: ref_lo1   = dat & 32'h03ff_ffff;
        tlb_pkg::ADR_ENTRYHI:  ref_hi    = dat & 32'hffff_e0ff; // vpn2 and asid
        default: ;
    endcase
endtask

function automatic logic ref_match(input tlb_pkg::vpn2_t vpn2, input tlb_pkg::asid_t asid,
                                   output tlb_pkg::tlb_idx_t idx);
    idx = '0;
    for (int i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin
        if (ref_tlb[i].used && ref_tlb[i].vpn2 == vpn2
            && (ref_tlb[i].g || ref_tlb[i].asid == asid)) begin
            idx = tlb_pkg::tlb_idx_t'(i);
            return 1'b1; // lowest index wins
        end
    end
    return 1'b0;
endfunction

function automatic tlb_pkg::tlb_result_t ref_lookup(input tlb_pkg::vpn_t vpn,
                                                    input tlb_pkg::asid_t asid);
    tlb_pkg::tlb_result_t r;
    tlb_pkg::tlb_idx_t    idx;
    r = '0;
    if (ref_match(vpn[19:1], asid, idx)) begin
        r.found = 1'b1;
        r.page  = vpn[0] ? ref_tlb[idx].page1 : ref_tlb[idx].page0;
    end
    return r;
endfunction

function automatic tlb_pkg::tlb_entry_t ref_entry_from_regs();
    tlb_pkg::tlb_entry_t e;
    e.used  = 1'b1;
    e.vpn2  = ref_hi[31:13];
    e.asid  = ref_hi[7:0];
    e.g     = ref_lo0[0] & ref_lo1[0];
    e.page0 = ref_lo0[25:1]; // pfn, c, d, v
    e.page1 = ref_lo1[25:1];
    return e;
endfunction

task automatic ref_command(input tlb_pkg::tlb_cmd_e cmd);
    tlb_pkg::tlb_idx_t   idx;
    tlb_pkg::tlb_entry_t e;
    case (cmd)
        tlb_pkg::CMD_TLBWI: ref_tlb[ref_index[3:0]] = ref_entry_from_regs();
        tlb_pkg::CMD_TLBWR: begin
            ref_tlb[ref_random] = ref_entry_from_regs();
            ref_random = ref_random - 4'd1;
        end
        tlb_pkg::CMD_TLBP: begin
            if (ref_match(ref_hi[31:13], ref_hi[7:0], idx)) begin
                ref_index = {28'b0, idx};
            end else begin
                ref_index[31] = 1'b1; // index bits kept
            end
        end
        default: begin
            e       = ref_tlb[ref_index[3:0]];
            ref_hi  = {e.vpn2, 5'b0, e.asid};
            ref_lo0 = {6'b0, e.page0, e.g};
            ref_lo1 = {6'b0, e.page1, e.g};
        end
    endcase
endtask

task automatic compare_word(input tlb_pkg::word_t got, input tlb_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
        end_with_failure($sformatf("FAILED at %0t ns: %s got %h expected %h",
                                   $time, what, got, exp));
    end
endtask

task automatic compare_result(input tlb_pkg::tlb_result_t got,
                              input tlb_pkg::tlb_result_t exp, input string what);
    if (got !== exp) begin
        end_with_failure($sformatf("FAILED at %0t ns: %s got %h expected %h",
                                   $time, what, got, exp));
    end
endtask

`endif

// File: tb/tlb_tb.sv
`timescale 1ns/100ps

module tlb_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int N_REG_ROUNDS = 4;
    localparam int N_LK_MIX     = 48;
    localparam int N_LK_ASID    = 24;
    localparam int N_RAND_WR    = 4;
    localparam int N_READ_CMD   = 4;
    localparam int BUS_OPS      = 8 + 8 * N_REG_ROUNDS + 6 * tlb_pkg::TLB_ENTRIES + 2
                                + 3 * tlb_pkg::TLB_ENTRIES + 4 + 8 * N_RAND_WR
                                + 5 * N_READ_CMD;
    localparam int LK_CYCLES    = N_LK_MIX + 2 * N_LK_ASID + N_RAND_WR + 12;
    localparam int WATCHDOG_NS  = (BUS_OPS + LK_CYCLES) * 20 * CLK_PERIOD + 1000;

    localparam tlb_pkg::vpn2_t POOL_BASE = 19'h00100; // pairs shared by several entries
    localparam tlb_pkg::asid_t ASID_A    = 8'h5a;
    localparam tlb_pkg::asid_t ASID_B    = 8'h33;

    typedef struct packed {
        tlb_pkg::vpn_t  vpn;
        tlb_pkg::asid_t asid;
    } look_t;

    logic                 aclk;
    logic                 rst;
    tlb_pkg::wb_req_t     wb_req;
    tlb_pkg::wb_rsp_t     wb_rsp;
    logic                 i_req_valid;
    tlb_pkg::vpn_t        i_req_vpn;
    logic                 i_res_valid;
    tlb_pkg::tlb_result_t i_res;
    logic                 d_req_valid;
    tlb_pkg::vpn_t        d_req_vpn;
    logic                 d_res_valid;
    tlb_pkg::tlb_result_t d_res;

    look_t i_q[$];
    look_t d_q[$];

    tlb_top dut_i (
        .aclk        (aclk        ),
        .rst         (rst         ),
        .wb_req      (wb_req      ),
        .wb_rsp      (wb_rsp      ),
        .i_req_valid (i_req_valid ),
        .i_req_vpn   (i_req_vpn   ),
        .i_res_valid (i_res_valid ),
        .i_res       (i_res       ),
        .d_req_valid (d_req_valid ),
        .d_req_vpn   (d_req_vpn   ),
        .d_res_valid (d_res_valid ),
        .d_res       (d_res       )
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    `include "tlb_tb_ref.svh"

    task automatic bus_cycle(input tlb_pkg::reg_adr_t adr, input logic we,
                             input tlb_pkg::word_t dat, output tlb_pkg::word_t rdat);
        int lat;
        int exp_lat;
        exp_lat = (we && adr == tlb_pkg::ADR_COMMAND) ? 2 : 1;
        lat     = 0;
        @(posedge aclk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(posedge aclk);
            #1;
            lat++;
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge aclk);
        #1;
        wb_req = '0; // stb drops the cycle after ack
        if (lat != exp_lat) begin
            end_with_failure($sformatf("FAILED at %0t ns: ack after %0d cycles, expected %0d",
                                       $time, lat, exp_lat));
        end
    endtask

    task automatic wb_write(input tlb_pkg::reg_adr_t adr, input tlb_pkg::word_t dat);
        tlb_pkg::word_t rd;
        bus_cycle(adr, 1'b1, dat, rd);
        ref_write_reg(adr, dat);
    endtask

    task automatic wb_read(input tlb_pkg::reg_adr_t adr, output tlb_pkg::word_t rd);
        bus_cycle(adr, 1'b0, '0, rd);
    endtask

    task automatic check_reg(input tlb_pkg::reg_adr_t adr);
        tlb_pkg::word_t rd;
        wb_read(adr, rd);
        compare_word(rd, ref_reg(adr), $sformatf("read of register %0d", adr));
    endtask

    task automatic tlb_cmd(input tlb_pkg::tlb_cmd_e cmd);
        wb_write(tlb_pkg::ADR_COMMAND, {30'b0, cmd});
        ref_command(cmd);
    endtask

    // pool pair with a random half, or a pair that is never written
    function automatic tlb_pkg::vpn_t pick_vpn();
        logic [31:0] r;
        r = $urandom;
        if (r[3:2] == 2'b11) begin
            return {3'b110, r[31:16], r[0]};
        end
        return {POOL_BASE + tlb_pkg::vpn2_t'(r[6:4]), r[0]};
    endfunction

    task automatic drive_lookups(input logic iv, input tlb_pkg::vpn_t ivpn,
                                 input logic dv, input tlb_pkg::vpn_t dvpn);
        @(posedge aclk);
        #1;
        i_req_valid = iv;
        i_req_vpn   = ivpn;
        d_req_valid = dv;
        d_req_vpn   = dvpn;
        if (iv) i_q.push_back({ivpn, ref_hi[7:0]});
        if (dv) d_q.push_back({dvpn, ref_hi[7:0]});
    endtask

    task automatic wait_lookups_done();
        drive_lookups(1'b0, '0, 1'b0, '0);
        while (i_q.size() != 0 || d_q.size() != 0) begin
            @(negedge aclk);
        end
    endtask

    task automatic run_lookups(input int n);
        logic [31:0] r;
        for (int c = 0; c < n; c++) begin
            r = $urandom;
            drive_lookups(r[0] | r[1], pick_vpn(), r[2] | r[3], pick_vpn());
        end
        wait_lookups_done();
    endtask

    // results are stable mid cycle
    always @(negedge aclk) begin
        look_t l;
        if (i_res_valid) begin
            if (i_q.size() == 0) begin
                end_with_failure("instruction port gave a result with no request pending");
            end else begin
                l = i_q.pop_front();
                compare_result(i_res, ref_lookup(l.vpn, l.asid), "itlb lookup");
            end
        end
        if (d_res_valid) begin
            if (d_q.size() == 0) begin
                end_with_failure("data port gave a result with no request pending");
            end else begin
                l = d_q.pop_front();
                compare_result(d_res, ref_lookup(l.vpn, l.asid), "dtlb lookup");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        end_with_failure("timeout: the test sequence did not complete in time");
    end

    initial begin
        tlb_pkg::word_t w;
        tlb_pkg::word_t rd;
        logic [31:0]    r;
        logic           g;
        void'($urandom(32'h4eba));
        aclk        = 1'b0;
        rst         = 1'b1;
        wb_req      = '0;
        i_req_valid = 1'b0;
        i_req_vpn   = '0;
        d_req_valid = 1'b0;
        d_req_vpn   = '0;
        ref_reset();
        repeat (3) @(posedge aclk);
        #1;
        rst = 1'b0;

        // register reset values and masking
        for (int a = 0; a < 6; a++) begin
            check_reg(tlb_pkg::reg_adr_t'(a));
        end
        wb_write(tlb_pkg::ADR_RANDOM, $urandom);
        check_reg(tlb_pkg::ADR_RANDOM);
        for (int n = 0; n < N_REG_ROUNDS; n++) begin
            for (int a = 0; a < 4; a++) begin
                wb_write(tlb_pkg::reg_adr_t'(a), $urandom);
                check_reg(tlb_pkg::reg_adr_t'(a));
            end
        end

        // fill all entries with two global ones
        for (int k = 0; k < tlb_pkg::TLB_ENTRIES; k++) begin
            r = $urandom;
            g = (k == 3 || k == 11);
            wb_write(tlb_pkg::ADR_ENTRYHI,
                     {POOL_BASE + tlb_pkg::vpn2_t'(r[2:0]), r[12:8], r[3] ? ASID_A : ASID_B});
            w    = $urandom;
            w[0] = g | r[4];
            wb_write(tlb_pkg::ADR_ENTRYLO0, w);
            w    = $urandom;
            w[0] = g;
            wb_write(tlb_pkg::ADR_ENTRYLO1, w);
            wb_write(tlb_pkg::ADR_INDEX, tlb_pkg::word_t'(k));
            tlb_cmd(tlb_pkg::CMD_TLBWI);
        end
        wb_write(tlb_pkg::ADR_ENTRYHI, {24'b0, ASID_A});
        run_lookups(N_LK_MIX);

        // switch the asid and then use one that no entry owns
        wb_write(tlb_pkg::ADR_ENTRYHI, {24'b0, ASID_B});
        run_lookups(N_LK_ASID);
        wb_write(tlb_pkg::ADR_ENTRYHI, 32'h0000_0077);
        run_lookups(N_LK_ASID);

        for (int k = 0; k < tlb_pkg::TLB_ENTRIES; k++) begin
            wb_write(tlb_pkg::ADR_ENTRYHI, {ref_tlb[k].vpn2, 5'b0, ref_tlb[k].asid});
            tlb_cmd(tlb_pkg::CMD_TLBP);
            check_reg(tlb_pkg::ADR_INDEX);
        end
        wb_write(tlb_pkg::ADR_INDEX, 32'd9);
        wb_write(tlb_pkg::ADR_ENTRYHI, {19'h7_ffff, 5'b0, ASID_A}); // absent pair
        tlb_cmd(tlb_pkg::CMD_TLBP);
        check_reg(tlb_pkg::ADR_INDEX);

        // random writes walk down from 15
        for (int n = 0; n < N_RAND_WR; n++) begin
            wb_write(tlb_pkg::ADR_ENTRYHI, {19'h4_0000 + tlb_pkg::vpn2_t'(n), 5'b0, ASID_A});
            wb_write(tlb_pkg::ADR_ENTRYLO0, $urandom);
            wb_write(tlb_pkg::ADR_ENTRYLO1, $urandom);
            tlb_cmd(tlb_pkg::CMD_TLBWR);
            wb_read(tlb_pkg::ADR_RANDOM, rd);
            compare_word(rd, tlb_pkg::word_t'(14 - n), "random after random write");
        end
        for (int n = 0; n < N_RAND_WR; n++) begin
            wb_write(tlb_pkg::ADR_ENTRYHI, {19'h4_0000 + tlb_pkg::vpn2_t'(n), 5'b0, ASID_A});
            tlb_cmd(tlb_pkg::CMD_TLBP);
            wb_read(tlb_pkg::ADR_INDEX, rd);
            compare_word(rd, tlb_pkg::word_t'(15 - n), "probe of random write slot");
        end
        for (int n = 0; n < N_RAND_WR; n++) begin
            drive_lookups(1'b1, {19'h4_0000 + tlb_pkg::vpn2_t'(n), 1'b0},
                          1'b1, {19'h4_0000 + tlb_pkg::vpn2_t'(n), 1'b1});
        end
        wait_lookups_done();

        // read command reloads the software registers
        for (int n = 0; n < N_READ_CMD; n++) begin
            wb_write(tlb_pkg::ADR_INDEX, $urandom % tlb_pkg::TLB_ENTRIES);
            tlb_cmd(tlb_pkg::CMD_TLBR);
            check_reg(tlb_pkg::ADR_ENTRYHI);
            check_reg(tlb_pkg::ADR_ENTRYLO0);
            check_reg(tlb_pkg::ADR_ENTRYLO1);
        end

        $display("Test passed");
        $finish;
    end

endmodule
